//--- mmuPkg.sv
package mmuPkg;

    // tlb operation codes, one strobe cycle each
    typedef enum logic [1:0] {
        TLB_NONE = 2'd0,
        TLB_WI   = 2'd1,
        TLB_R    = 2'd2,
        TLB_P    = 2'd3
    } tlbOpE;

    // one 4 KB page per entry
    localparam int unsigned VPN_W = 20;
    localparam int unsigned PFN_W = 20;
    localparam int unsigned ASID_W = 8;

    // top nibble codes of the unmapped kernel segments
    // kseg0, cached, bit 31 cleared
    localparam logic [3:0] SEG_KSEG0_LO = 4'h8;
    localparam logic [3:0] SEG_KSEG0_HI = 4'h9;
    // kseg1, uncached, bits 31..29 cleared
    localparam logic [3:0] SEG_KSEG1_LO = 4'hA;
    localparam logic [3:0] SEG_KSEG1_HI = 4'hB;

    // EntryLo C field value that marks a page uncached
    localparam logic [2:0] C_UNCACHED = 3'd2;

endpackage

//--- tlbArray.sv
`timescale 1ns/1ps

module tlbArray #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    // write port, TLBWI
    input  logic                             wrEn,
    input  logic [$clog2(TLB_ENTRIES)-1:0]   wrIdx,
    input  logic [mmuPkg::VPN_W-1:0]         wrVpn,
    input  logic [mmuPkg::ASID_W-1:0]        wrAsid,
    input  logic                             wrG,
    input  logic [mmuPkg::PFN_W-1:0]         wrPfn,
    input  logic [2:0]                       wrC,
    input  logic                             wrD,
    input  logic                             wrV,
    // read port, TLBR
    input  logic [$clog2(TLB_ENTRIES)-1:0]   rdIdx,
    output logic [mmuPkg::VPN_W-1:0]         rdVpn,
    output logic [mmuPkg::ASID_W-1:0]        rdAsid,
    output logic                             rdG,
    output logic [mmuPkg::PFN_W-1:0]         rdPfn,
    output logic [2:0]                       rdC,
    output logic                             rdD,
    output logic                             rdV,
    // data translation lookup
    input  logic [mmuPkg::VPN_W-1:0]         lookupVpn,
    input  logic [mmuPkg::ASID_W-1:0]        lookupAsid,
    output logic                             found,
    output logic [mmuPkg::PFN_W-1:0]         hitPfn,
    output logic [2:0]                       hitC,
    output logic                             hitD,
    output logic                             hitV,
    // probe lookup, TLBP
    input  logic [mmuPkg::VPN_W-1:0]         probeVpn,
    input  logic [mmuPkg::ASID_W-1:0]        probeAsid,
    output logic                             probeHit,
    output logic [$clog2(TLB_ENTRIES)-1:0]   probeIdx
);
    import mmuPkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // per-entry fields
    logic [VPN_W-1:0]  entVpn  [TLB_ENTRIES];
    logic [ASID_W-1:0] entAsid [TLB_ENTRIES];
    logic              entG    [TLB_ENTRIES];
    logic [PFN_W-1:0]  entPfn  [TLB_ENTRIES];
    logic [2:0]        entC    [TLB_ENTRIES];
    logic              entD    [TLB_ENTRIES];
    logic              entV    [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] lookupMatch;
    logic [TLB_ENTRIES-1:0] probeMatch;
    logic [IDX_W-1:0]       hitIdx;

    // vpn equal and either global or same asid
    function automatic logic [TLB_ENTRIES-1:0] matchVec(
        input logic [VPN_W-1:0]  vpn,
        input logic [ASID_W-1:0] asid
    );
        logic [TLB_ENTRIES-1:0] m;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m[i] = (entVpn[i] == vpn) && (entG[i] || (entAsid[i] == asid));
        end
        return m;
    endfunction

    // lowest set bit wins, scan from the top down
    function automatic logic [IDX_W-1:0] lowestIdx(input logic [TLB_ENTRIES-1:0] m);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // storage, everything invalid after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entVpn[i]  <= '0;
                entAsid[i] <= '0;
                entG[i]    <= 1'b0;
                entPfn[i]  <= '0;
                entC[i]    <= '0;
                entD[i]    <= 1'b0;
                entV[i]    <= 1'b0;
            end
        end else if (wrEn) begin
            entVpn[wrIdx]  <= wrVpn;
            entAsid[wrIdx] <= wrAsid;
            entG[wrIdx]    <= wrG;
            entPfn[wrIdx]  <= wrPfn;
            entC[wrIdx]    <= wrC;
            entD[wrIdx]    <= wrD;
            entV[wrIdx]    <= wrV;
        end
    end

    // read port
    assign rdVpn  = entVpn[rdIdx];
    assign rdAsid = entAsid[rdIdx];
    assign rdG    = entG[rdIdx];
    assign rdPfn  = entPfn[rdIdx];
    assign rdC    = entC[rdIdx];
    assign rdD    = entD[rdIdx];
    assign rdV    = entV[rdIdx];

    // translation match, fields of entry 0 on a miss
    assign lookupMatch = matchVec(lookupVpn, lookupAsid);
    assign found       = |lookupMatch;
    assign hitIdx      = lowestIdx(lookupMatch);
    assign hitPfn      = entPfn[hitIdx];
    assign hitC        = entC[hitIdx];
    assign hitD        = entD[hitIdx];
    assign hitV        = entV[hitIdx];

    // probe match against EntryHi
    assign probeMatch = matchVec(probeVpn, probeAsid);
    assign probeHit   = |probeMatch;
    assign probeIdx   = lowestIdx(probeMatch);

endmodule

//--- dtlbStage.sv
`timescale 1ns/1ps

module dtlbStage (
    input  logic [31:0]              vAddr,
    input  logic                     read,
    input  logic                     store,
    // lookup result from the tlb
    input  logic                     found,
    input  logic [mmuPkg::PFN_W-1:0] hitPfn,
    input  logic [2:0]               hitC,
    input  logic                     hitD,
    input  logic                     hitV,
    output logic [31:0]              rAddr,
    output logic                     isUncache,
    output logic                     exRdRefill,
    output logic                     exWrRefill,
    output logic                     exRdInvalid,
    output logic                     exWrInvalid,
    output logic                     exModified
);
    import mmuPkg::*;

    // page offset bits below the vpn
    localparam int OFS_W = 32 - VPN_W;

    logic [3:0] seg;
    logic       isKseg0;
    logic       isKseg1;
    logic       mapped;

    assign seg     = vAddr[31:28];
    assign isKseg0 = (seg == SEG_KSEG0_LO) || (seg == SEG_KSEG0_HI);
    assign isKseg1 = (seg == SEG_KSEG1_LO) || (seg == SEG_KSEG1_HI);
    // kuseg, kseg2 and kseg3 go through the tlb
    assign mapped  = !isKseg0 && !isKseg1;

    // physical address
    always_comb begin
        if (isKseg1) begin
            rAddr = {3'b000, vAddr[28:0]};
        end else if (isKseg0) begin
            rAddr = {1'b0, vAddr[30:0]};
        end else if (found) begin
            rAddr = {hitPfn, vAddr[OFS_W-1:0]};
        end else begin
            // mapped miss
            rAddr = '0;
        end
    end

    // kseg1 always uncached, mapped pages by their C field
    always_comb begin
        if (isKseg1) begin
            isUncache = 1'b1;
        end else if (mapped && found) begin
            isUncache = (hitC == C_UNCACHED);
        end else begin
            isUncache = 1'b0;
        end
    end

    // refill on a mapped miss
    assign exRdRefill  = mapped && !found && read;
    assign exWrRefill  = mapped && !found && store;
    // invalid on a hit with V clear
    assign exRdInvalid = mapped && found && !hitV && read;
    assign exWrInvalid = mapped && found && !hitV && store;
    // store to a clean valid page
    assign exModified  = mapped && found && hitV && !hitD && store;

endmodule

//--- tlbCp0Regs.sv
`timescale 1ns/1ps

module tlbCp0Regs #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    // MTC0 style writes
    input  logic                             entryHiWe,
    input  logic [31:0]                      entryHiIn,
    input  logic                             entryLoWe,
    input  logic [31:0]                      entryLoIn,
    input  logic                             indexWe,
    input  logic [31:0]                      indexIn,
    input  mmuPkg::tlbOpE                    tlbOp,
    // tlb read port fields
    input  logic [mmuPkg::VPN_W-1:0]         rdVpn,
    input  logic [mmuPkg::ASID_W-1:0]        rdAsid,
    input  logic                             rdG,
    input  logic [mmuPkg::PFN_W-1:0]         rdPfn,
    input  logic [2:0]                       rdC,
    input  logic                             rdD,
    input  logic                             rdV,
    // probe result
    input  logic                             probeHit,
    input  logic [$clog2(TLB_ENTRIES)-1:0]   probeIdx,
    output logic [31:0]                      entryHi,
    output logic [31:0]                      entryLo,
    output logic [31:0]                      index,
    output logic [mmuPkg::ASID_W-1:0]        curAsid,
    // tlb write port
    output logic                             wrEn,
    output logic [$clog2(TLB_ENTRIES)-1:0]   wrIdx,
    output logic [mmuPkg::VPN_W-1:0]         wrVpn,
    output logic [mmuPkg::ASID_W-1:0]        wrAsid,
    output logic                             wrG,
    output logic [mmuPkg::PFN_W-1:0]         wrPfn,
    output logic [2:0]                       wrC,
    output logic                             wrD,
    output logic                             wrV,
    output logic [$clog2(TLB_ENTRIES)-1:0]   rdIdx,
    output logic [mmuPkg::VPN_W-1:0]         probeVpn,
    output logic [mmuPkg::ASID_W-1:0]        probeAsid
);
    import mmuPkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // EntryHi: vpn 31..12, asid 7..0, bits 11..8 read as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            entryHi <= '0;
        end else if (tlbOp == TLB_R) begin
            entryHi <= {rdVpn, 4'b0000, rdAsid};
        end else if (entryHiWe) begin
            entryHi <= {entryHiIn[31:12], 4'b0000, entryHiIn[7:0]};
        end
    end

    // EntryLo: pfn 25..6, C 5..3, D V G, upper bits read as zero
    always_ff @(posedge clk) begin
        if (reset) begin
            entryLo <= '0;
        end else if (tlbOp == TLB_R) begin
            entryLo <= {6'b000000, rdPfn, rdC, rdD, rdV, rdG};
        end else if (entryLoWe) begin
            entryLo <= {6'b000000, entryLoIn[25:0]};
        end
    end

    // Index: probe failure in bit 31, entry number in the low bits
    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (tlbOp == TLB_P) begin
            if (probeHit) begin
                index <= {{(32 - IDX_W){1'b0}}, probeIdx};
            end else begin
                index <= 32'h8000_0000;
            end
        end else if (indexWe) begin
            // software cannot set the probe flag
            index <= {{(32 - IDX_W){1'b0}}, indexIn[IDX_W-1:0]};
        end
    end

    assign curAsid = entryHi[7:0];

    // TLBWI takes the entry straight from the registers
    assign wrEn   = (tlbOp == TLB_WI);
    assign wrIdx  = index[IDX_W-1:0];
    assign wrVpn  = entryHi[31:12];
    assign wrAsid = entryHi[7:0];
    assign wrPfn  = entryLo[25:6];
    assign wrC    = entryLo[5:3];
    assign wrD    = entryLo[2];
    assign wrV    = entryLo[1];
    assign wrG    = entryLo[0];

    // TLBR reads the entry Index points at
    assign rdIdx = index[IDX_W-1:0];

    // TLBP searches for the EntryHi pair
    assign probeVpn  = entryHi[31:12];
    assign probeAsid = entryHi[7:0];

endmodule

//--- dataMmu.sv
`timescale 1ns/1ps

module dataMmu #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   vAddr,
    input  logic          read,
    input  logic          store,
    input  logic          entryHiWe,
    input  logic [31:0]   entryHiIn,
    input  logic          entryLoWe,
    input  logic [31:0]   entryLoIn,
    input  logic          indexWe,
    input  logic [31:0]   indexIn,
    input  mmuPkg::tlbOpE tlbOp,
    output logic [31:0]   rAddr,
    output logic          isUncache,
    output logic          exRdRefill,
    output logic          exWrRefill,
    output logic          exRdInvalid,
    output logic          exWrInvalid,
    output logic          exModified,
    output logic [31:0]   entryHi,
    output logic [31:0]   entryLo,
    output logic [31:0]   index
);
    import mmuPkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [ASID_W-1:0] curAsid;
    // write port
    logic              wrEn;
    logic [IDX_W-1:0]  wrIdx;
    logic [VPN_W-1:0]  wrVpn;
    logic [ASID_W-1:0] wrAsid;
    logic              wrG;
    logic [PFN_W-1:0]  wrPfn;
    logic [2:0]        wrC;
    logic              wrD;
    logic              wrV;
    // read port
    logic [IDX_W-1:0]  rdIdx;
    logic [VPN_W-1:0]  rdVpn;
    logic [ASID_W-1:0] rdAsid;
    logic              rdG;
    logic [PFN_W-1:0]  rdPfn;
    logic [2:0]        rdC;
    logic              rdD;
    logic              rdV;
    // probe
    logic [VPN_W-1:0]  probeVpn;
    logic [ASID_W-1:0] probeAsid;
    logic              probeHit;
    logic [IDX_W-1:0]  probeIdx;
    // translation hit
    logic              found;
    logic [PFN_W-1:0]  hitPfn;
    logic [2:0]        hitC;
    logic              hitD;
    logic              hitV;

    tlbCp0Regs #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlbCp0Regs (
        .clk       (clk),
        .reset     (reset),
        .entryHiWe (entryHiWe),
        .entryHiIn (entryHiIn),
        .entryLoWe (entryLoWe),
        .entryLoIn (entryLoIn),
        .indexWe   (indexWe),
        .indexIn   (indexIn),
        .tlbOp     (tlbOp),
        .rdVpn     (rdVpn),
        .rdAsid    (rdAsid),
        .rdG       (rdG),
        .rdPfn     (rdPfn),
        .rdC       (rdC),
        .rdD       (rdD),
        .rdV       (rdV),
        .probeHit  (probeHit),
        .probeIdx  (probeIdx),
        .entryHi   (entryHi),
        .entryLo   (entryLo),
        .index     (index),
        .curAsid   (curAsid),
        .wrEn      (wrEn),
        .wrIdx     (wrIdx),
        .wrVpn     (wrVpn),
        .wrAsid    (wrAsid),
        .wrG       (wrG),
        .wrPfn     (wrPfn),
        .wrC       (wrC),
        .wrD       (wrD),
        .wrV       (wrV),
        .rdIdx     (rdIdx),
        .probeVpn  (probeVpn),
        .probeAsid (probeAsid)
    );

    // lookup uses the vpn of the data address and the current asid
    tlbArray #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_tlbArray (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .wrIdx      (wrIdx),
        .wrVpn      (wrVpn),
        .wrAsid     (wrAsid),
        .wrG        (wrG),
        .wrPfn      (wrPfn),
        .wrC        (wrC),
        .wrD        (wrD),
        .wrV        (wrV),
        .rdIdx      (rdIdx),
        .rdVpn      (rdVpn),
        .rdAsid     (rdAsid),
        .rdG        (rdG),
        .rdPfn      (rdPfn),
        .rdC        (rdC),
        .rdD        (rdD),
        .rdV        (rdV),
        .lookupVpn  (vAddr[31:32-VPN_W]),
        .lookupAsid (curAsid),
        .found      (found),
        .hitPfn     (hitPfn),
        .hitC       (hitC),
        .hitD       (hitD),
        .hitV       (hitV),
        .probeVpn   (probeVpn),
        .probeAsid  (probeAsid),
        .probeHit   (probeHit),
        .probeIdx   (probeIdx)
    );

    dtlbStage u_dtlbStage (
        .vAddr       (vAddr),
        .read        (read),
        .store       (store),
        .found       (found),
        .hitPfn      (hitPfn),
        .hitC        (hitC),
        .hitD        (hitD),
        .hitV        (hitV),
        .rAddr       (rAddr),
        .isUncache   (isUncache),
        .exRdRefill  (exRdRefill),
        .exWrRefill  (exWrRefill),
        .exRdInvalid (exRdInvalid),
        .exWrInvalid (exWrInvalid),
        .exModified  (exModified)
    );

endmodule

//--- dataMmuTb.sv
`timescale 1ns/1ps

module dataMmuTb;
    import mmuPkg::*;

    localparam int TLB_N = 16;
    localparam int IDX_W = $clog2(TLB_N);
    localparam int N_UNMAPPED = 24;
    localparam int N_REFILL = 8;
    localparam int N_ENTRIES = 8;
    // an access takes 1 cycle, a register write 2 and a tlb operation 2
    localparam int TEST_CYCLES = 8 + N_UNMAPPED + 2 * N_REFILL + 4 * N_ENTRIES
                               + 2 * (2 + 2 * N_ENTRIES) + 6 * N_ENTRIES + 4;
    localparam int MARGIN = 100;

    logic        clk;
    logic        reset;
    logic [31:0] vAddr;
    logic        read;
    logic        store;
    logic        entryHiWe;
    logic [31:0] entryHiIn;
    logic        entryLoWe;
    logic [31:0] entryLoIn;
    logic        indexWe;
    logic [31:0] indexIn;
    tlbOpE       tlbOp;
    logic [31:0] rAddr;
    logic        isUncache;
    logic        exRdRefill;
    logic        exWrRefill;
    logic        exRdInvalid;
    logic        exWrInvalid;
    logic        exModified;
    logic [31:0] entryHi;
    logic [31:0] entryLo;
    logic [31:0] index;

    // shadow copy of the cp0 registers
    logic [31:0] shHi;
    logic [31:0] shLo;
    logic [31:0] shIdx;
    // shadow copy of every tlb entry
    logic [VPN_W-1:0]  shVpn  [TLB_N];
    logic [ASID_W-1:0] shAsid [TLB_N];
    logic              shG    [TLB_N];
    logic [PFN_W-1:0]  shPfn  [TLB_N];
    logic [2:0]        shC    [TLB_N];
    logic              shD    [TLB_N];
    logic              shV    [TLB_N];
    // vpn and asid of the entries written by the test with slot 0 unused
    logic [VPN_W-1:0]  tVpn   [N_ENTRIES + 1];
    logic [ASID_W-1:0] tAsid  [N_ENTRIES + 1];
    logic [15:0]       lfsr;

    dataMmu #(
        .TLB_ENTRIES(TLB_N)
    ) u_dataMmu (
        .clk         (clk),
        .reset       (reset),
        .vAddr       (vAddr),
        .read        (read),
        .store       (store),
        .entryHiWe   (entryHiWe),
        .entryHiIn   (entryHiIn),
        .entryLoWe   (entryLoWe),
        .entryLoIn   (entryLoIn),
        .indexWe     (indexWe),
        .indexIn     (indexIn),
        .tlbOp       (tlbOp),
        .rAddr       (rAddr),
        .isUncache   (isUncache),
        .exRdRefill  (exRdRefill),
        .exWrRefill  (exWrRefill),
        .exRdInvalid (exRdInvalid),
        .exWrInvalid (exWrInvalid),
        .exModified  (exModified),
        .entryHi     (entryHi),
        .entryLo     (entryLo),
        .index       (index)
    );

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // random address outside kseg0 and kseg1
    function automatic logic [31:0] mappedAddr();
        logic [31:0] a;
        a = randBits(32);
        // 8..B moved up to C..F
        if (a[31:30] == 2'b10) begin
            a[30] = 1'b1;
        end
        return a;
    endfunction

    // {hit, index} of the first matching shadow entry
    function automatic logic [IDX_W:0] lookupShadow(
        input logic [VPN_W-1:0]  vpn,
        input logic [ASID_W-1:0] asid
    );
        logic [IDX_W:0] res;
        res = '0;
        for (int i = 0; i < TLB_N; i++) begin
            if (!res[IDX_W] && shVpn[i] == vpn && (shG[i] || shAsid[i] == asid)) begin
                res = {1'b1, IDX_W'(i)};
            end
        end
        return res;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s expected 0x%h got 0x%h", name, exp, got);
            $display("CHECKS FAILED");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic checkRegs();
        compareValue("entryHi", entryHi, shHi);
        compareValue("entryLo", entryLo, shLo);
        compareValue("index", index, shIdx);
    endtask

    // one cycle of data access with the outputs checked mid cycle
    task automatic access(input logic [31:0] addr, input logic rd, input logic st);
        logic [IDX_W:0]   res;
        logic [IDX_W-1:0] e;
        logic [31:0]      expAddr;
        logic             expUnc;
        logic             expRdRef;
        logic             expWrRef;
        logic             expRdInv;
        logic             expWrInv;
        logic             expMod;
        @(posedge clk);
        #2;
        vAddr = addr;
        read = rd;
        store = st;
        res = lookupShadow(addr[31:12], shHi[7:0]);
        e = res[IDX_W-1:0];
        expUnc = 1'b0;
        expRdRef = 1'b0;
        expWrRef = 1'b0;
        expRdInv = 1'b0;
        expWrInv = 1'b0;
        expMod = 1'b0;
        if (addr[31:28] == SEG_KSEG0_LO || addr[31:28] == SEG_KSEG0_HI) begin
            expAddr = addr & 32'h7FFF_FFFF;
        end else if (addr[31:28] == SEG_KSEG1_LO || addr[31:28] == SEG_KSEG1_HI) begin
            expAddr = addr & 32'h1FFF_FFFF;
            expUnc = 1'b1;
        end else if (!res[IDX_W]) begin
            // tlb miss
            expAddr = 32'h0;
            expRdRef = rd;
            expWrRef = st;
        end else begin
            expAddr = {shPfn[e], addr[11:0]};
            expUnc = (shC[e] == C_UNCACHED);
            expRdInv = !shV[e] && rd;
            expWrInv = !shV[e] && st;
            expMod = shV[e] && !shD[e] && st;
        end
        #8;
        compareValue("rAddr", rAddr, expAddr);
        compareValue("isUncache", 32'(isUncache), 32'(expUnc));
        compareValue("exRdRefill", 32'(exRdRefill), 32'(expRdRef));
        compareValue("exWrRefill", 32'(exWrRefill), 32'(expWrRef));
        compareValue("exRdInvalid", 32'(exRdInvalid), 32'(expRdInv));
        compareValue("exWrInvalid", 32'(exWrInvalid), 32'(expWrInv));
        compareValue("exModified", 32'(exModified), 32'(expMod));
    endtask

    // MTC0 of all three registers in one cycle
    task automatic writeRegs(input logic [31:0] hi, input logic [31:0] lo,
                             input logic [31:0] idx);
        @(posedge clk);
        #2;
        entryHiWe = 1'b1;
        entryHiIn = hi;
        entryLoWe = 1'b1;
        entryLoIn = lo;
        indexWe = 1'b1;
        indexIn = idx;
        @(posedge clk);
        #2;
        entryHiWe = 1'b0;
        entryLoWe = 1'b0;
        indexWe = 1'b0;
        // only the architected fields are kept
        shHi = {hi[31:12], 4'h0, hi[7:0]};
        shLo = {6'h0, lo[25:0]};
        shIdx = {{(32 - IDX_W){1'b0}}, idx[IDX_W-1:0]};
        #8;
        checkRegs();
    endtask

    task automatic runTlbOp(input tlbOpE op);
        logic [IDX_W:0]   res;
        logic [IDX_W-1:0] e;
        @(posedge clk);
        #2;
        tlbOp = op;
        @(posedge clk);
        #2;
        tlbOp = TLB_NONE;
        e = shIdx[IDX_W-1:0];
        case (op)
            TLB_WI: begin
                shVpn[e] = shHi[31:12];
                shAsid[e] = shHi[7:0];
                shPfn[e] = shLo[25:6];
                shC[e] = shLo[5:3];
                shD[e] = shLo[2];
                shV[e] = shLo[1];
                shG[e] = shLo[0];
            end
            TLB_R: begin
                shHi = {shVpn[e], 4'h0, shAsid[e]};
                shLo = {6'h0, shPfn[e], shC[e], shD[e], shV[e], shG[e]};
            end
            TLB_P: begin
                res = lookupShadow(shHi[31:12], shHi[7:0]);
                if (res[IDX_W]) begin
                    shIdx = {{(32 - IDX_W){1'b0}}, res[IDX_W-1:0]};
                end else begin
                    shIdx = 32'h8000_0000;
                end
            end
            default: begin
            end
        endcase
        #8;
        checkRegs();
    endtask

    // time limit from the test length
    initial begin
        #((TEST_CYCLES + MARGIN) * 20);
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] lo;
        logic [7:0]  procAsid;
        logic [7:0]  otherAsid;
        clk = 1'b0;
        reset = 1'b1;
        vAddr = '0;
        read = 1'b0;
        store = 1'b0;
        entryHiWe = 1'b0;
        entryHiIn = '0;
        entryLoWe = 1'b0;
        entryLoIn = '0;
        indexWe = 1'b0;
        indexIn = '0;
        tlbOp = TLB_NONE;
        lfsr = 16'd40140;
        shHi = '0;
        shLo = '0;
        shIdx = '0;
        // state right after reset
        for (int i = 0; i < TLB_N; i++) begin
            shVpn[i] = '0;
            shAsid[i] = '0;
            shG[i] = 1'b0;
            shPfn[i] = '0;
            shC[i] = '0;
            shD[i] = 1'b0;
            shV[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        #8;
        checkRegs();

        // kseg0 and kseg1 keep every flag low even with read and store
        for (int i = 0; i < N_UNMAPPED; i++) begin
            a = randBits(32);
            a[31:29] = (i % 2 == 1) ? 3'b101 : 3'b100;
            r = randBits(2);
            access(a, r[0], r[1]);
        end

        // empty tlb so every mapped access refills
        // vpn 0 avoided since reset entries hold it
        for (int i = 0; i < N_REFILL; i++) begin
            a = mappedAddr();
            if (a[31:12] == 20'h0) begin
                a[12] = 1'b1;
            end
            access(a, 1'b1, 1'b0);
            access(a, 1'b0, 1'b1);
        end

        r = randBits(8);
        procAsid = r[7:0];
        otherAsid = procAsid ^ 8'h3C;
        // distinct vpns through the low nibble
        for (int k = 1; k <= N_ENTRIES; k++) begin
            a = mappedAddr();
            tVpn[k] = {a[31:16], 4'(k)};
            tAsid[k] = (k == 4 || k == 5) ? otherAsid : procAsid;
            lo = randBits(26);
            // corner entries for uncached, invalid, clean and global
            if (k == 1) begin
                lo[5:3] = C_UNCACHED;
                lo[1] = 1'b1;
            end
            if (k == 2) begin
                lo[1] = 1'b0;
            end
            if (k == 3) begin
                lo[2] = 1'b0;
                lo[1] = 1'b1;
            end
            lo[0] = (k == 4);
            writeRegs({tVpn[k], 4'h0, tAsid[k]}, lo, 32'((k * 5) % TLB_N));
            runTlbOp(TLB_WI);
        end

        // the second pass uses the other asid where only entry 4 and entry 5 hit
        for (int pass = 0; pass < 2; pass++) begin
            writeRegs({24'h0, (pass == 0) ? procAsid : otherAsid}, 32'h0, 32'h0);
            for (int k = 1; k <= N_ENTRIES; k++) begin
                r = randBits(12);
                access({tVpn[k], r[11:0]}, 1'b1, 1'b0);
                access({tVpn[k], r[11:0]}, 1'b0, 1'b1);
            end
        end

        // probe finds each entry and read brings its fields back
        for (int k = 1; k <= N_ENTRIES; k++) begin
            writeRegs({tVpn[k], 4'h0, tAsid[k]}, 32'h0, 32'h0);
            runTlbOp(TLB_P);
            runTlbOp(TLB_R);
        end
        // low nibble 0 was never written so the probe misses
        a = mappedAddr();
        writeRegs({4'hC, a[27:16], 4'h0, 4'h0, procAsid}, 32'h0, 32'h0);
        runTlbOp(TLB_P);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- dataMmu.f
mmuPkg.sv
tlbArray.sv
dtlbStage.sv
tlbCp0Regs.sv
dataMmu.sv
dataMmuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dataMmuTb
FILELIST  ?= dataMmu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
